/* hw/sdmac_pkg.sv */
// Shared encodings for the SDMAC register block and the bus data is always 32 bits wide
package sdmac_pkg;

  // Bus widths
  localparam int ADDR_W = 8;   // Register offset from the CPU
  localparam int DATA_W = 32;  // CPU data bus

  // One decoded command per bus cycle
  typedef enum logic [3:0] {
    OP_NONE     = 4'd0,   // No command on the interface
    OP_WTC      = 4'd1,   // 0x04 word transfer count
    OP_CNTR     = 4'd2,   // 0x08 control register
    OP_ACR      = 4'd3,   // 0x0C address counter
    OP_ST_DMA   = 4'd4,   // 0x10 start strobe
    OP_FLUSH    = 4'd5,   // 0x14 flush strobe
    OP_CLR_INT  = 4'd6,   // 0x18 interrupt clear strobe
    OP_ISTR     = 4'd7,   // 0x1C interrupt status, read only
    OP_VERSION  = 4'd8,   // 0x20 version id, read only
    OP_SP_DMA   = 4'd9,   // 0x3C stop strobe
    OP_WD       = 4'd10,  // 0x40..0x4F SCSI chip window
    OP_UNMAPPED = 4'd11   // Anything else
  } reg_op_e;

  // Word engine
  typedef enum logic {
    DMA_IDLE = 1'b0,
    DMA_RUN  = 1'b1
  } dma_state_e;

  // CNTR layout
  localparam int CNTR_DMADIR = 1;  // Transfer direction
  localparam int CNTR_INTEN  = 2;  // Interrupt enable
  localparam int CNTR_W      = CNTR_INTEN + 1;  // Upper bits read as zero

  // ISTR layout
  localparam int ISTR_INT_DONE = 0;  // Count reached zero
  localparam int ISTR_FE_FLG   = 1;  // FIFO empty after flush
  localparam int ISTR_DMA_ACT  = 2;  // Engine running
  localparam int ISTR_W        = ISTR_DMA_ACT + 1;

  // ACR moves one longword per beat
  localparam int ACR_STEP = 4;

endpackage

/* hw/sdmac_ifs.sv */
// Command and register view links between the SDMAC blocks and the view WTC width must match the register block
`timescale 1ns/10ps

// Decoder to register file and read path
interface sdmac_cmd_if;

  logic                          cmd_valid;  // One cycle per bus cycle
  sdmac_pkg::reg_op_e            cmd_op;
  logic                          cmd_wr;     // High for CPU write
  logic [sdmac_pkg::DATA_W-1:0]  cmd_wdata;

  modport dec (
    output cmd_valid,
    output cmd_op,
    output cmd_wr,
    output cmd_wdata
  );

  modport exe (
    input cmd_valid,
    input cmd_op,
    input cmd_wr,
    input cmd_wdata
  );

endinterface

// Live register contents for the read path
interface sdmac_view_if #(
  parameter int WTC_W = 24
);

  logic [WTC_W-1:0]              wtc;
  logic [sdmac_pkg::DATA_W-1:0]  acr;
  logic [sdmac_pkg::CNTR_W-1:0]  cntr;
  logic [sdmac_pkg::ISTR_W-1:0]  istr;

  modport src (
    output wtc,
    output acr,
    output cntr,
    output istr
  );

  modport snk (
    input wtc,
    input acr,
    input cntr,
    input istr
  );

endinterface

/* hw/sdmac_addr_decode.sv */
// Address strobe decoder that needs addr rw and wdata held stable while as_n is low and as_n high for one sample between cycles
`timescale 1ns/10ps

module sdmac_addr_decode (
  input  logic                          sclk,
  input  logic                          reset,
  input  logic [sdmac_pkg::ADDR_W-1:0]  addr,
  input  logic                          cs_n,
  input  logic                          as_n,
  input  logic                          rw,     // High for read
  input  logic [sdmac_pkg::DATA_W-1:0]  wdata,
  output logic                          wd_sel,
  sdmac_cmd_if.dec                      cmd
);

  localparam logic [3:0] WD_PAGE = 4'h4;  // 0x40..0x4F

  logic strobe_q;    // Chip select and address strobe both low at last edge
  logic cycle_open;  // Command already issued for this strobe
  logic start;

  // Offset to opcode
  function automatic sdmac_pkg::reg_op_e addr_to_op(input logic [sdmac_pkg::ADDR_W-1:0] a);
    sdmac_pkg::reg_op_e op;
    case (a)
      8'h04:   op = sdmac_pkg::OP_WTC;
      8'h08:   op = sdmac_pkg::OP_CNTR;
      8'h0C:   op = sdmac_pkg::OP_ACR;
      8'h10:   op = sdmac_pkg::OP_ST_DMA;
      8'h14:   op = sdmac_pkg::OP_FLUSH;
      8'h18:   op = sdmac_pkg::OP_CLR_INT;
      8'h1C:   op = sdmac_pkg::OP_ISTR;
      8'h20:   op = sdmac_pkg::OP_VERSION;
      8'h3C:   op = sdmac_pkg::OP_SP_DMA;
      default: op = sdmac_pkg::OP_UNMAPPED;
    endcase
    if (a[7:4] == WD_PAGE) op = sdmac_pkg::OP_WD;  // Whole page goes to the SCSI chip
    return op;
  endfunction

  assign start = strobe_q & ~cycle_open;  // First sampled edge of a new strobe

  // Strobe tracking
  always_ff @(posedge sclk) begin
    if (reset) begin
      strobe_q      <= 1'b0;
      cycle_open    <= 1'b0;
      wd_sel        <= 1'b0;
      cmd.cmd_valid <= 1'b0;
    end else begin
      strobe_q      <= ~cs_n & ~as_n;
      wd_sel        <= ~cs_n & ~as_n & (addr[7:4] == WD_PAGE);  // Follows the strobe
      cmd.cmd_valid <= start;
      if (start)
        cycle_open <= 1'b1;
      else if (!strobe_q)
        cycle_open <= 1'b0;  // Strobe gone so rearm
    end
  end

  // Command payload
  always_ff @(posedge sclk) begin
    cmd.cmd_op <= start ? addr_to_op(addr) : sdmac_pkg::OP_NONE;
    if (start) begin
      cmd.cmd_wr    <= ~rw;
      cmd.cmd_wdata <= wdata;
    end
  end

  // One pulse per strobe even when the CPU holds as_n for many cycles
  a_single_cmd: assert property (@(posedge sclk) disable iff (reset)
    cmd.cmd_valid |=> !cmd.cmd_valid)
    else $error("cmd_valid high on consecutive cycles");

endmodule

/* hw/sdmac_regs.sv */
// Register file and word engine where a command overrides the engine step and no data moves
`timescale 1ns/10ps

module sdmac_regs #(
  parameter int WTC_W = 24  // 8 to 32
) (
  input  logic      sclk,
  input  logic      reset,
  sdmac_cmd_if.exe  cmd,
  input  logic      dreq,   // SCSI side word request
  output logic      dack,
  sdmac_view_if.src view
);

  localparam logic [WTC_W-1:0] WTC_ONE = WTC_W'(1);
  localparam logic [sdmac_pkg::DATA_W-1:0] ACR_INC = sdmac_pkg::DATA_W'(sdmac_pkg::ACR_STEP);

  sdmac_pkg::dma_state_e         state;
  logic [WTC_W-1:0]              wtc;
  logic [sdmac_pkg::DATA_W-1:0]  acr;
  logic [sdmac_pkg::CNTR_W-1:0]  cntr;
  logic                          int_done;  // Transfer complete
  logic                          fe_flg;    // Flush seen
  logic                          last_beat;

  // Beat accepted this cycle
  assign dack      = (state == sdmac_pkg::DMA_RUN) && dreq && (wtc != '0);
  assign last_beat = dack && (wtc == WTC_ONE);

  always_ff @(posedge sclk) begin
    if (reset) begin
      state    <= sdmac_pkg::DMA_IDLE;
      wtc      <= '0;
      acr      <= '0;
      cntr     <= '0;
      int_done <= 1'b0;
      fe_flg   <= 1'b0;
    end else begin
      // Engine step first so a command below can override it
      if (dack) begin
        wtc <= wtc - WTC_ONE;
        acr <= acr + ACR_INC;  // Next longword
        if (last_beat) begin
          state    <= sdmac_pkg::DMA_IDLE;
          int_done <= 1'b1;
        end
      end else if (state == sdmac_pkg::DMA_RUN && wtc == '0) begin
        state <= sdmac_pkg::DMA_IDLE;  // Count cleared by a write while running
      end

      if (cmd.cmd_valid) begin
        case (cmd.cmd_op)
          sdmac_pkg::OP_WTC: begin
            if (cmd.cmd_wr) wtc <= cmd.cmd_wdata[WTC_W-1:0];
          end
          sdmac_pkg::OP_CNTR: begin
            if (cmd.cmd_wr) cntr <= cmd.cmd_wdata[sdmac_pkg::CNTR_W-1:0];
          end
          sdmac_pkg::OP_ACR: begin
            if (cmd.cmd_wr) acr <= cmd.cmd_wdata;
          end
          // Action strobes fire on read or write
          sdmac_pkg::OP_ST_DMA: begin
            if (wtc != '0) state <= sdmac_pkg::DMA_RUN;  // Nothing to move otherwise
          end
          sdmac_pkg::OP_SP_DMA: begin
            state <= sdmac_pkg::DMA_IDLE;  // Count and address kept for restart
          end
          sdmac_pkg::OP_FLUSH: begin
            state  <= sdmac_pkg::DMA_IDLE;
            wtc    <= '0;
            fe_flg <= 1'b1;
          end
          sdmac_pkg::OP_CLR_INT: begin
            int_done <= 1'b0;
            fe_flg   <= 1'b0;
          end
          default: ;  // Reads and the SCSI window leave state alone
        endcase
      end
    end
  end

  // Status view
  always_comb begin
    view.istr                          = '0;
    view.istr[sdmac_pkg::ISTR_INT_DONE] = int_done;
    view.istr[sdmac_pkg::ISTR_FE_FLG]   = fe_flg;
    view.istr[sdmac_pkg::ISTR_DMA_ACT]  = (state == sdmac_pkg::DMA_RUN);
  end

  assign view.wtc  = wtc;
  assign view.acr  = acr;
  assign view.cntr = cntr;

  // Beats only once a start strobe has put the engine in DMA_RUN
  a_dack_run: assert property (@(posedge sclk) disable iff (reset)
    dack |-> $past(state) == sdmac_pkg::DMA_RUN ||
             $past(cmd.cmd_valid && cmd.cmd_op == sdmac_pkg::OP_ST_DMA))
    else $error("dack outside DMA_RUN");

  // Count must never wrap below zero
  a_dack_wtc: assert property (@(posedge sclk) disable iff (reset)
    dack && !cmd.cmd_valid |=> wtc < $past(wtc))
    else $error("dack with zero word count");

endmodule

/* hw/sdmac_read_mux.sv */
// Read data and bus acknowledge where rdata holds the last read and int_n is a level from live register state
`timescale 1ns/10ps

module sdmac_read_mux #(
  parameter int              WTC_W      = 24,
  parameter logic [31:0]     VERSION_ID = 32'h0000_0001
) (
  input  logic                          sclk,
  input  logic                          reset,
  input  logic                          as_n,
  sdmac_cmd_if.exe                      cmd,
  sdmac_view_if.snk                     view,
  output logic [sdmac_pkg::DATA_W-1:0]  rdata,
  output logic                          dtack_n,
  output logic                          int_n
);

  localparam int DW = sdmac_pkg::DATA_W;

  logic [DW-1:0] rd_sel;  // Value for the current command

  // Zero extended register select
  always_comb begin
    case (cmd.cmd_op)
      sdmac_pkg::OP_WTC:     rd_sel = DW'(view.wtc[WTC_W-1:0]);
      sdmac_pkg::OP_CNTR:    rd_sel = DW'(view.cntr);
      sdmac_pkg::OP_ACR:     rd_sel = view.acr;
      sdmac_pkg::OP_ISTR:    rd_sel = DW'(view.istr);
      sdmac_pkg::OP_VERSION: rd_sel = DW'(VERSION_ID);
      default:               rd_sel = '0;  // Strobes, SCSI window, holes
    endcase
  end

  always_ff @(posedge sclk) begin
    if (reset) begin
      rdata   <= '0;
      dtack_n <= 1'b1;
    end else begin
      if (cmd.cmd_valid && !cmd.cmd_wr) rdata <= rd_sel;  // Writes keep old data
      if (as_n)
        dtack_n <= 1'b1;  // CPU ended the cycle
      else if (cmd.cmd_valid)
        dtack_n <= 1'b0;
    end
  end

  // Level interrupt, masked by INTEN
  assign int_n = ~(view.istr[sdmac_pkg::ISTR_INT_DONE] & view.cntr[sdmac_pkg::CNTR_INTEN]);

  // Ack released once the strobe has been seen high
  a_dtack_release: assert property (@(posedge sclk) disable iff (reset)
    $past(as_n) |-> dtack_n)
    else $error("dtack_n low after as_n high for a cycle");

endmodule

/* hw/sdmac_top.sv */
// SDMAC register block top where WTC_W must be 8 to 32 and the SCSI chip window is only signalled on wd_sel
`timescale 1ns/10ps

module sdmac_top #(
  parameter int          WTC_W      = 24,
  parameter logic [31:0] VERSION_ID = 32'h0000_0001
) (
  input  logic                          sclk,
  input  logic                          reset,
  // CPU bus
  input  logic [sdmac_pkg::ADDR_W-1:0]  addr,
  input  logic                          cs_n,
  input  logic                          as_n,
  input  logic                          rw,
  input  logic [sdmac_pkg::DATA_W-1:0]  wdata,
  output logic [sdmac_pkg::DATA_W-1:0]  rdata,
  output logic                          dtack_n,
  output logic                          int_n,
  // SCSI side
  input  logic                          dreq,
  output logic                          dack,
  output logic                          wd_sel
);

  sdmac_cmd_if                      cmd_if ();
  sdmac_view_if #(.WTC_W(WTC_W))    view_if ();

  // Bus cycle to command
  sdmac_addr_decode sdmac_addr_decode_inst (
    .sclk   (sclk),
    .reset  (reset),
    .addr   (addr),
    .cs_n   (cs_n),
    .as_n   (as_n),
    .rw     (rw),
    .wdata  (wdata),
    .wd_sel (wd_sel),
    .cmd    (cmd_if.dec)
  );

  // Registers and word engine
  sdmac_regs #(.WTC_W(WTC_W)) sdmac_regs_inst (
    .sclk  (sclk),
    .reset (reset),
    .cmd   (cmd_if.exe),
    .dreq  (dreq),
    .dack  (dack),
    .view  (view_if.src)
  );

  // Read data and acknowledge
  sdmac_read_mux #(
    .WTC_W      (WTC_W),
    .VERSION_ID (VERSION_ID)
  ) sdmac_read_mux_inst (
    .sclk    (sclk),
    .reset   (reset),
    .as_n    (as_n),
    .cmd     (cmd_if.exe),
    .view    (view_if.snk),
    .rdata   (rdata),
    .dtack_n (dtack_n),
    .int_n   (int_n)
  );

endmodule

/* verification/sdmac_checker.sv */
// Pin level SDMAC model that expects one access at a time and as_n high between accesses
`timescale 1ns/10ps

module sdmac_checker #(
  parameter int          WTC_W      = 24,
  parameter logic [31:0] VERSION_ID = 32'h0
) (
  input  logic        sclk,
  input  logic        reset,
  input  logic [7:0]  addr,
  input  logic        cs_n,
  input  logic        as_n,
  input  logic        rw,
  input  logic [31:0] wdata,
  input  logic [31:0] rdata,
  input  logic        dtack_n,
  input  logic        int_n,
  input  logic        dreq,
  input  logic        dack,
  input  logic        wd_sel,
  output int          value_errors,
  output int          signal_errors
);

  int               data_errs = 0;
  int               sig_errs  = 0;
  logic             armed     = 1'b0;  // Model valid once reset was seen
  logic             run;
  logic [WTC_W-1:0] wtc;
  logic [31:0]      acr;
  logic [2:0]       cntr;
  logic             int_done, fe_flg;
  logic             open_q;            // Strobe already taken
  int               wait_cnt = 0;      // Cycles until the access lands
  logic [7:0]       cmd_addr;
  logic             cmd_wr;
  logic [31:0]      cmd_data;
  logic             dtack_exp, wd_exp, rd_check;
  logic [31:0]      rdata_exp;
  int               beats, load_wtc;   // dack pulses since the last WTC write

  assign value_errors  = data_errs;
  assign signal_errors = sig_errs;

  task automatic check_sig(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s: expected %h actual %h", $time, name, exp, act);
      sig_errs++;
    end
  endtask

  // Register map, zero extended
  function automatic logic [31:0] read_value(input logic [7:0] a);
    case (a)
      8'h04:   return 32'(wtc);
      8'h08:   return 32'(cntr);
      8'h0C:   return acr;
      8'h1C:   return 32'({run, fe_flg, int_done});  // DMA_ACT FE_FLG INT_DONE
      8'h20:   return VERSION_ID;
      default: return '0;                          // Strobes, SCSI window, holes
    endcase
  endfunction

  // Outputs are settled at the falling edge
  always @(negedge sclk) begin
    logic dack_e;
    logic apply;
    dack_e = run && dreq && (wtc != '0);
    if (armed) begin
      check_sig("dtack_n", 32'(dtack_exp), 32'(dtack_n));
      check_sig("dack", 32'(dack_e), 32'(dack));
      check_sig("int_n", 32'(!(int_done && cntr[2])), 32'(int_n));  // INTEN is bit 2
      check_sig("wd_sel", 32'(wd_exp), 32'(wd_sel));
      if (rd_check && rdata !== rdata_exp) begin
        $display("[FAIL] %0t rdata: expected %h actual %h at address %h",
                 $time, rdata_exp, rdata, cmd_addr);
        data_errs++;
      end
    end
    rd_check = 1'b0;
    if (reset) begin
      {run, int_done, fe_flg, open_q, wd_exp} = '0;
      wtc       = '0;
      acr       = '0;
      cntr      = '0;
      wait_cnt  = 0;
      beats     = 0;
      load_wtc  = 0;
      dtack_exp = 1'b1;
      rdata_exp = '0;
      rd_check  = 1'b1;  // rdata must read zero after reset
      armed     = 1'b1;
    end else begin
      if (dack) beats++;
      wd_exp = !cs_n && !as_n && (addr[7:4] == 4'h4);
      apply  = (wait_cnt == 1);  // Lands at the coming edge
      if (wait_cnt > 0) wait_cnt--;
      if (!cs_n && !as_n && !open_q) begin
        open_q   = 1'b1;
        wait_cnt = 2;            // Sampled at the next edge, acted on two later
        cmd_addr = addr;
        cmd_wr   = !rw;
        cmd_data = wdata;
      end else if (as_n) begin
        open_q = 1'b0;
      end
      if (as_n) dtack_exp = 1'b1;
      else if (apply) dtack_exp = 1'b0;
      if (apply && !cmd_wr) begin
        rdata_exp = read_value(cmd_addr);  // Value before this edge
        rd_check  = 1'b1;
      end
      // Word engine
      if (dack_e) begin
        if (wtc == WTC_W'(1)) begin
          run      = 1'b0;
          int_done = 1'b1;
          check_sig("dack count", 32'(load_wtc), 32'(beats));
        end
        wtc = wtc - WTC_W'(1);
        acr = acr + 32'd4;
      end else if (run && wtc == '0) begin
        run = 1'b0;
      end
      // Bus command wins over the engine
      if (apply) begin
        case (cmd_addr)
          8'h04: if (cmd_wr) begin
            wtc      = cmd_data[WTC_W-1:0];
            load_wtc = int'(cmd_data[WTC_W-1:0]);
            beats    = 0;
          end
          8'h08: if (cmd_wr) cntr = cmd_data[2:0];
          8'h0C: if (cmd_wr) acr = cmd_data;
          8'h10: if (wtc != '0) run = 1'b1;
          8'h3C: run = 1'b0;
          8'h14: begin
            run    = 1'b0;
            wtc    = '0;
            fe_flg = 1'b1;
          end
          8'h18: {int_done, fe_flg} = 2'b00;
          default: ;
        endcase
      end
    end
  end

endmodule

/* verification/tb_sdmac.sv */
// Seeded random bus and dreq stimulus for the SDMAC top while sdmac_checker does the comparing
`timescale 1ns/10ps

module tb_sdmac;

  localparam int          WTC_W      = 16;  // Narrower than default so masking shows
  localparam logic [31:0] VERSION_ID = 32'h5344_0102;
  localparam int          CLK_NS     = 40;
  localparam int          MAX_N      = 40;  // Longest random transfer
  localparam int          BUS_CYC    = 10;  // One access plus idle gap
  localparam int          TEST_CYC   = 3 + 120 * BUS_CYC + 5 * (4 * MAX_N + BUS_CYC);
  localparam int          LIMIT_NS   = 4 * TEST_CYC * CLK_NS;

  logic        sclk, reset, cs_n, as_n, rw, dreq;
  logic [7:0]  addr;
  logic [31:0] wdata, rdata;
  logic        dtack_n, int_n, dack, wd_sel;
  integer      seed;
  logic [31:0] rnd;       // Draws of the bus thread
  logic [31:0] dreq_rnd;
  int          value_errors, signal_errors;

  sdmac_top #(.WTC_W(WTC_W), .VERSION_ID(VERSION_ID)) sdmac_top_inst (.*);

  sdmac_checker #(.WTC_W(WTC_W), .VERSION_ID(VERSION_ID)) sdmac_checker_inst (.*);

  initial sclk = 1'b0;
  always #(CLK_NS / 2) sclk = ~sclk;

  // Word requests on about half the cycles
  initial begin
    dreq = 1'b0;
    forever begin
      @(negedge sclk);
      dreq_rnd = $random(seed);
      @(posedge sclk);
      dreq <= dreq_rnd[0];
    end
  end

  initial begin
    #(LIMIT_NS);
    $display("timeout: run still busy after %0d ns", LIMIT_NS);
    $display("tests failed");
    $finish;
  end

  // One strobe cycle, held until dtack_n
  task automatic access(input logic [7:0] a, input logic wr, input logic [31:0] d,
                        output logic [31:0] q);
    @(posedge sclk);
    addr  <= a;
    rw    <= ~wr;
    wdata <= d;
    cs_n  <= 1'b0;
    as_n  <= 1'b0;
    @(posedge sclk);
    while (dtack_n !== 1'b0) @(posedge sclk);
    q = rdata;
    cs_n <= 1'b1;
    as_n <= 1'b1;
    repeat (2) @(posedge sclk);  // Decoder rearms
  endtask

  task automatic write_reg(input logic [7:0] a, input logic [31:0] d);
    logic [31:0] q;
    access(a, 1'b1, d, q);
  endtask

  task automatic read_reg(input logic [7:0] a);
    logic [31:0] q;
    access(a, 1'b0, 32'h0, q);
  endtask

  // Poll ISTR until DMA_ACT drops
  task automatic wait_idle();
    logic [31:0] q;
    q = 32'h4;
    while (q[2]) access(8'h1C, 1'b0, 32'h0, q);
  endtask

  task automatic start_run(input logic [31:0] n);
    rnd = $random(seed);
    write_reg(8'h04, n);
    write_reg(8'h0C, {rnd[31:2], 2'b00});
    write_reg(8'h10, rnd);  // Start strobe
  endtask

  task automatic run_transfer(input logic inten);
    rnd = $random(seed);
    write_reg(8'h08, {rnd[31:3], inten, rnd[1:0]});
    rnd = $random(seed);
    start_run(1 + rnd % MAX_N);
    wait_idle();
    read_reg(8'h04);
    read_reg(8'h0C);
    read_reg(8'h1C);
    write_reg(8'h18, rnd);  // Clear interrupt
    read_reg(8'h1C);
  endtask

  task automatic stop_restart();
    rnd = $random(seed);
    start_run(20 + rnd % 20);  // Outlasts the stop delay
    rnd = $random(seed);
    repeat (4 + rnd % 6) @(posedge sclk);
    write_reg(8'h3C, rnd);
    read_reg(8'h04);
    read_reg(8'h1C);
    write_reg(8'h10, rnd);     // Resume from kept count
    wait_idle();
    read_reg(8'h04);
    read_reg(8'h0C);
  endtask

  task automatic flush_mid_run();
    rnd = $random(seed);
    start_run(20 + rnd % 20);
    repeat (3) @(posedge sclk);
    write_reg(8'h14, rnd);
    read_reg(8'h04);
    read_reg(8'h1C);           // FE_FLG set
    write_reg(8'h18, rnd);
    read_reg(8'h1C);
  endtask

  initial begin
    logic [31:0] q;
    seed  = 57044;
    reset = 1'b1;
    cs_n  = 1'b1;
    as_n  = 1'b1;
    rw    = 1'b1;
    addr  = '0;
    wdata = '0;
    repeat (3) @(posedge sclk);
    reset <= 1'b0;
    for (int i = 0; i < 8; i++) begin  // Write and read back
      rnd = $random(seed);
      write_reg(8'h08, rnd);
      rnd = $random(seed);
      write_reg(8'h0C, rnd);
      rnd = $random(seed);
      write_reg(8'h04, rnd);
      read_reg(8'h08);
      read_reg(8'h0C);
      read_reg(8'h04);
    end
    read_reg(8'h20);                   // VERSION
    for (int i = 0; i < 6; i++) begin
      rnd = $random(seed);
      read_reg({1'b1, rnd[6:0]});      // Upper half is all holes
    end
    read_reg(8'h00);
    read_reg(8'h24);
    for (int i = 0; i < 6; i++) begin  // SCSI chip window
      rnd = $random(seed);
      access({4'h4, rnd[3:0]}, rnd[4], rnd, q);
    end
    run_transfer(1'b1);
    run_transfer(1'b0);
    stop_restart();
    flush_mid_run();
    repeat (4) @(posedge sclk);
    $display("closing: value errors %0d signal errors %0d", value_errors, signal_errors);
    if (value_errors + signal_errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

/* verilog.f */
hw/sdmac_pkg.sv
hw/sdmac_ifs.sv
hw/sdmac_addr_decode.sv
hw/sdmac_regs.sv
hw/sdmac_read_mux.sv
hw/sdmac_top.sv
verification/sdmac_checker.sv
verification/tb_sdmac.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SDMAC testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_sdmac -f verilog.f -o Vtb_sdmac
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_sdmac > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" "$LOG"; then
  exit 1
fi
exit 0
